//--- hw/irtcv_defs.svh
`ifndef IRTCV_DEFS_SVH
`define IRTCV_DEFS_SVH

// Register and datapath widths
`define IRTCV_SYSFR_W    28   // System clock frequency register
`define IRTCV_FR_W       20   // Carrier frequency register
`define IRTCV_CNT_W      16   // Period and duty counts
`define IRTCV_DR_W       16   // Data word, mark flag on top
`define IRTCV_CR_W       4    // Control register

// Divider sizing
`define IRTCV_DIV_STEPS  28   // One quotient bit per step
`define IRTCV_DIVCNT_W   5

// Control register bit positions
`define IRTCV_CR_EN      0    // Enable
`define IRTCV_CR_DT33    1    // One-third duty instead of half
`define IRTCV_CR_OPOL    2    // Output polarity, level of an idle ir_out
`define IRTCV_CR_DISOE   3    // Mute output on data error

`endif

//--- hw/irtcv_pkg.sv
`include "irtcv_defs.svh"

package irtcv_pkg;

   // Plain vectors for the widths that carry a meaning
   typedef logic [`IRTCV_SYSFR_W-1:0] sysfr_t;         // Hz
   typedef logic [`IRTCV_FR_W-1:0]    carrier_freq_t;  // Hz
   typedef logic [`IRTCV_CNT_W-1:0]   carrier_cnt_t;   // System clocks
   typedef logic [`IRTCV_DR_W-1:0]    tx_word_t;       // {mark, length}
   typedef logic [`IRTCV_DR_W-2:0]    burst_len_t;     // Carrier periods
   typedef logic [`IRTCV_CR_W-1:0]    ctrl_reg_t;
   typedef logic [3:0]                status_t;        // {busy, tip, daterr, drdy}
   typedef logic [`IRTCV_SYSFR_W-1:0] div_word_t;

   // Transmit sequencer
   typedef enum logic [1:0] {
      tx_idle     = 2'b00,
      tx_init     = 2'b01,
      tx_transmit = 2'b11
   } tx_state_e;

   // Period division first, then the duty division
   typedef enum logic [2:0] {
      cal_idle, cal_per_start, cal_per_run, cal_per_fin,
      cal_duty_start, cal_duty_run, cal_duty_fin
   } cal_state_e;

   typedef enum logic [1:0] {
      div_idle   = 2'b00,
      div_init   = 2'b01,
      div_calc   = 2'b11,
      div_adjust = 2'b10
   } div_state_e;

endpackage

//--- hw/irtcv_divider.sv
`timescale 1ns/10ps
`include "irtcv_defs.svh"

module irtcv_divider (
   input  logic                 irtcv_clk,
   input  logic                 irtcv_rst_async,
   input  logic                 enable,
   input  logic                 div_start,     // One cycle, operands stable
   input  irtcv_pkg::div_word_t dividend,
   input  irtcv_pkg::div_word_t divisor,
   output logic                 div_fin,       // Quotient valid this cycle
   output irtcv_pkg::div_word_t quotient
);

   import irtcv_pkg::*;

   localparam int dw = $bits(div_word_t);
   localparam logic [`IRTCV_DIVCNT_W-1:0] last_step =
      `IRTCV_DIVCNT_W'(`IRTCV_DIV_STEPS - 1);

   div_state_e                 div_state;
   div_state_e                 div_next;
   logic [`IRTCV_DIVCNT_W-1:0] step_cnt;
   div_word_t                  div_q;          // Dividend out at the top, quotient in below
   div_word_t                  div_rem;
   div_word_t                  div_dvsr;
   logic [dw:0]                sub_a;
   logic [dw:0]                sub_val;
   logic                       sub_neg;
   logic                       calc_done;
   logic                       round_up;

   // ********************************************************************
   // Step control
   assign calc_done = (div_state == div_calc) && (step_cnt == last_step);

   always_comb begin
      div_next = div_state;
      case (div_state)
         div_idle:   if (div_start) div_next = div_init;
         div_init:   div_next = div_calc;
         div_calc:   if (calc_done) div_next = div_adjust;
         div_adjust: div_next = div_idle;
         default:    div_next = div_idle;
      endcase
   end

   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async)          div_state <= div_idle;
      else if (!enable)             div_state <= div_idle;
      else                          div_state <= div_next;
   end

   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async)          step_cnt <= '0;
      else if (div_state == div_init) step_cnt <= '0;
      else if (div_state == div_calc) step_cnt <= step_cnt + `IRTCV_DIVCNT_W'(1);
   end

   // ********************************************************************
   // Datapath, one shared subtractor
   // During adjust the doubled remainder is compared with the divisor,
   // i.e. remainder against half the divisor
   assign sub_a   = (div_state == div_adjust) ? {div_rem, 1'b0} : {div_rem, div_q[dw-1]};
   assign sub_val = sub_a - {1'b0, div_dvsr};
   assign sub_neg = sub_val[dw];

   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async) begin
         div_q    <= '0;
         div_rem  <= '0;
         div_dvsr <= '0;
      end else if (div_state == div_init) begin
         div_q    <= dividend;
         div_rem  <= '0;
         div_dvsr <= divisor;
      end else if (div_state == div_calc) begin
         div_q   <= {div_q[dw-2:0], ~sub_neg};
         div_rem <= sub_neg ? sub_a[dw-1:0] : sub_val[dw-1:0];   // Restore on borrow
      end
   end

   assign round_up = (div_state == div_adjust) && !sub_neg;
   assign div_fin  = (div_state == div_adjust);
   assign quotient = div_q + div_word_t'(round_up);   // Round half up

   // Start only from idle, and the result follows at a fixed latency
   a_div_start_idle: assert property (
      @(posedge irtcv_clk) disable iff (irtcv_rst_async || !enable)
      div_start |-> (div_state == div_idle) ##(`IRTCV_DIV_STEPS + 2) div_fin
   );

endmodule

//--- hw/irtcv_carrier_calc.sv
`timescale 1ns/10ps
`include "irtcv_defs.svh"

module irtcv_carrier_calc (
   input  logic                     irtcv_clk,
   input  logic                     irtcv_rst_async,
   input  logic                     enable,
   input  logic                     dt33,         // Divide period by 3 instead of 2
   input  logic                     irtcvfr_wt,
   input  irtcv_pkg::sysfr_t        irsysfr,
   input  irtcv_pkg::carrier_freq_t irtcvfr,
   output irtcv_pkg::carrier_cnt_t  period,
   output irtcv_pkg::carrier_cnt_t  duty,
   output logic                     cal_busy
);

   import irtcv_pkg::*;

   cal_state_e cal_state;
   cal_state_e cal_next;
   logic       div_start;
   logic       div_fin;
   logic       duty_phase;
   div_word_t  dividend;
   div_word_t  divisor;
   div_word_t  quotient;

   // ********************************************************************
   // Calculation sequencer
   always_comb begin
      cal_next = cal_state;
      case (cal_state)
         cal_idle:       if (irtcvfr_wt) cal_next = cal_per_start;
         cal_per_start:  cal_next = cal_per_run;
         cal_per_run:    if (div_fin) cal_next = cal_per_fin;
         cal_per_fin:    cal_next = cal_duty_start;   // Period register settles
         cal_duty_start: cal_next = cal_duty_run;
         cal_duty_run:   if (div_fin) cal_next = cal_duty_fin;
         cal_duty_fin:   cal_next = cal_idle;
         default:        cal_next = cal_idle;
      endcase
   end

   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async)  cal_state <= cal_idle;
      else if (!enable)     cal_state <= cal_idle;
      else                  cal_state <= cal_next;
   end

   assign cal_busy   = (cal_state != cal_idle);
   assign div_start  = (cal_state == cal_per_start) || (cal_state == cal_duty_start);
   assign duty_phase = (cal_state == cal_duty_start) || (cal_state == cal_duty_run);

   // Operand selection, held for the whole run
   assign dividend = duty_phase ? div_word_t'(period) : div_word_t'(irsysfr);
   assign divisor  = duty_phase ? (dt33 ? div_word_t'(3) : div_word_t'(2))
                                : div_word_t'(irtcvfr);

   irtcv_divider irtcv_divider_inst (
      .irtcv_clk       (irtcv_clk),
      .irtcv_rst_async (irtcv_rst_async),
      .enable          (enable),
      .div_start       (div_start),
      .dividend        (dividend),
      .divisor         (divisor),
      .div_fin         (div_fin),
      .quotient        (quotient)
   );

   // Results
   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async)                        period <= '1;
      else if ((cal_state == cal_per_run) && div_fin) period <= quotient[`IRTCV_CNT_W-1:0];
   end

   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async)                         duty <= '0;
      else if ((cal_state == cal_duty_run) && div_fin) duty <= quotient[`IRTCV_CNT_W-1:0];
   end

   // Both divisions back to back from a frequency write
   a_cal_latency: assert property (
      @(posedge irtcv_clk) disable iff (irtcv_rst_async || !enable)
      ((cal_state == cal_idle) && irtcvfr_wt)
         |=> cal_busy [*(2 * (`IRTCV_DIV_STEPS + 4))] ##1 !cal_busy
   );

endmodule

//--- hw/irtcv_tx_seq.sv
`timescale 1ns/10ps
`include "irtcv_defs.svh"

module irtcv_tx_seq (
   input  logic                 irtcv_clk,
   input  logic                 irtcv_rst_async,
   input  logic                 exe,          // Execute, level
   input  irtcv_pkg::ctrl_reg_t irtcvcr,
   input  logic                 irtcvcr_wt,
   input  logic                 irtcvdr_wt,
   input  logic                 cal_busy,
   input  logic                 word_cap,     // Word boundary, next word taken
   output logic                 tx_active,
   output logic                 tx_mute,
   output irtcv_pkg::status_t   status
);

   import irtcv_pkg::*;

   logic      enable;
   logic      disoe;
   logic [1:0] exe_sense;
   logic      execute;
   logic      exe_rise;
   tx_state_e tx_state;
   tx_state_e tx_next;
   logic      tx_stop;
   logic      busy;
   logic      tip;
   logic      drdy;
   logic      drdy_clr;
   logic      drdy_set;
   logic      daterr;
   logic      daterr_clr;
   logic      daterr_set;

   assign enable = irtcvcr[`IRTCV_CR_EN];
   assign disoe  = irtcvcr[`IRTCV_CR_DISOE];

   // ********************************************************************
   // Execute sensing
   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async) exe_sense <= 2'b00;
      else if (enable)     exe_sense <= {exe, exe_sense[1]};
      else                 exe_sense <= 2'b00;
   end

   assign execute  = exe_sense[1];
   assign exe_rise = exe_sense[1] & ~exe_sense[0];

   // ********************************************************************
   // Transmit state machine
   // Stop at a word boundary, or at once when the error mutes the output
   assign tx_stop = ~execute & (word_cap | (daterr & disoe));

   always_comb begin
      tx_next = tx_state;
      case (tx_state)
         tx_idle: begin
            if (exe_rise) tx_next = tx_init;
         end
         tx_init: begin
            if (!execute)                tx_next = tx_idle;
            else if (!cal_busy && !drdy) tx_next = tx_transmit;   // First word written
         end
         tx_transmit: begin
            if (tx_stop)                 tx_next = tx_idle;
            else if (word_cap && drdy)   tx_next = tx_init;       // Underrun, wait for data
         end
         default: tx_next = tx_idle;
      endcase
   end

   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async) tx_state <= tx_idle;
      else if (enable)     tx_state <= tx_next;
      else                 tx_state <= tx_idle;
   end

   assign tx_active = (tx_state == tx_transmit);
   assign tx_mute   = daterr & disoe;

   // ********************************************************************
   // Status flags
   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async) busy <= 1'b0;
      else                 busy <= (enable && (tx_next != tx_idle)) || cal_busy;
   end

   assign tip = (tx_state == tx_transmit);

   // Data buffer ready, a write empties the ready state
   assign drdy_clr = irtcvdr_wt;
   assign drdy_set = word_cap | irtcvcr_wt;

   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async) drdy <= 1'b1;
      else if (drdy_clr)   drdy <= 1'b0;
      else if (drdy_set)   drdy <= 1'b1;
   end

   assign daterr_clr = exe_rise | irtcvcr_wt;
   assign daterr_set = word_cap & drdy;   // Word taken but none written

   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async) daterr <= 1'b0;
      else if (daterr_clr) daterr <= 1'b0;
      else if (daterr_set) daterr <= 1'b1;
   end

   assign status = {busy, tip, daterr, drdy};

   // Disable takes the sequencer out of transmit by the next cycle
   a_no_tx_disabled: assert property (
      @(posedge irtcv_clk) disable iff (irtcv_rst_async)
      !enable |=> (tx_state != tx_transmit)
   );

endmodule

//--- hw/irtcv_burst_gen.sv
`timescale 1ns/10ps
`include "irtcv_defs.svh"

module irtcv_burst_gen (
   input  logic                    irtcv_clk,
   input  logic                    irtcv_rst_async,
   input  logic                    tx_active,
   input  logic                    tx_mute,
   input  logic                    opol,       // Idle level of ir_out
   input  irtcv_pkg::carrier_cnt_t period,
   input  irtcv_pkg::carrier_cnt_t duty,
   input  irtcv_pkg::tx_word_t     irtcvdr,
   output logic                    word_cap,
   output logic                    ir_out
);

   import irtcv_pkg::*;

   carrier_cnt_t carr_cnt;      // 1 .. period within a carrier period
   burst_len_t   burst_cnt;     // Periods left in the word, this one included
   burst_len_t   new_len;
   logic         mark;
   logic         period_end;
   logic         last_period;
   logic         ir_drive;

   // ********************************************************************
   // Carrier and burst counters
   // Outside transmit both counters park on a word boundary, so the first
   // transmit cycle takes a word
   assign period_end  = (carr_cnt >= period);
   assign last_period = (burst_cnt == burst_len_t'(1));
   assign word_cap    = tx_active & period_end & last_period;

   assign new_len = (irtcvdr[`IRTCV_DR_W-2:0] == '0) ? burst_len_t'(1)
                                                     : irtcvdr[`IRTCV_DR_W-2:0];

   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async)  carr_cnt <= '1;
      else if (!tx_active)  carr_cnt <= '1;
      else if (period_end)  carr_cnt <= carrier_cnt_t'(1);
      else                  carr_cnt <= carr_cnt + carrier_cnt_t'(1);
   end

   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async) begin
         burst_cnt <= burst_len_t'(1);
         mark      <= 1'b0;
      end else if (!tx_active) begin
         burst_cnt <= burst_len_t'(1);
      end else if (word_cap) begin
         burst_cnt <= new_len;
         mark      <= irtcvdr[`IRTCV_DR_W-1];   // Stale word if none was written
      end else if (period_end) begin
         burst_cnt <= burst_cnt - burst_len_t'(1);
      end
   end

   // ********************************************************************
   // Output register
   // Active for the first duty clocks of every period of a mark word
   assign ir_drive = tx_active & ~tx_mute & mark & (carr_cnt <= duty);

   always_ff @(posedge irtcv_clk or posedge irtcv_rst_async) begin
      if (irtcv_rst_async) ir_out <= 1'b0;
      else                 ir_out <= ir_drive ? ~opol : opol;
   end

endmodule

//--- hw/irtcv_ctrl.sv
`timescale 1ns/10ps
`include "irtcv_defs.svh"

module irtcv_ctrl (
   input  logic                     irtcv_clk,
   input  logic                     irtcv_rst_async,
   input  logic                     exe,          // Execute, level
   input  irtcv_pkg::ctrl_reg_t     irtcvcr,
   input  irtcv_pkg::sysfr_t        irsysfr,
   input  irtcv_pkg::carrier_freq_t irtcvfr,
   input  irtcv_pkg::tx_word_t      irtcvdr,
   input  logic                     irtcvcr_wt,
   input  logic                     irtcvfr_wt,   // Starts the carrier calculation
   input  logic                     irtcvdr_wt,
   output logic                     ir_out,
   output irtcv_pkg::status_t       status
);

   import irtcv_pkg::*;

   carrier_cnt_t period;
   carrier_cnt_t duty;
   logic         cal_busy;
   logic         word_cap;
   logic         tx_active;
   logic         tx_mute;

   irtcv_carrier_calc irtcv_carrier_calc_inst (
      .irtcv_clk       (irtcv_clk),
      .irtcv_rst_async (irtcv_rst_async),
      .enable          (irtcvcr[`IRTCV_CR_EN]),
      .dt33            (irtcvcr[`IRTCV_CR_DT33]),
      .irtcvfr_wt      (irtcvfr_wt),
      .irsysfr         (irsysfr),
      .irtcvfr         (irtcvfr),
      .period          (period),
      .duty            (duty),
      .cal_busy        (cal_busy)
   );

   irtcv_tx_seq irtcv_tx_seq_inst (
      .irtcv_clk       (irtcv_clk),
      .irtcv_rst_async (irtcv_rst_async),
      .exe             (exe),
      .irtcvcr         (irtcvcr),
      .irtcvcr_wt      (irtcvcr_wt),
      .irtcvdr_wt      (irtcvdr_wt),
      .cal_busy        (cal_busy),
      .word_cap        (word_cap),
      .tx_active       (tx_active),
      .tx_mute         (tx_mute),
      .status          (status)
   );

   irtcv_burst_gen irtcv_burst_gen_inst (
      .irtcv_clk       (irtcv_clk),
      .irtcv_rst_async (irtcv_rst_async),
      .tx_active       (tx_active),
      .tx_mute         (tx_mute),
      .opol            (irtcvcr[`IRTCV_CR_OPOL]),
      .period          (period),
      .duty            (duty),
      .irtcvdr         (irtcvdr),
      .word_cap        (word_cap),
      .ir_out          (ir_out)
   );

endmodule

//--- verif/irtcv_clk_gen.sv
`timescale 1ns/10ps

module irtcv_clk_gen (
   output logic irtcv_clk,
   output logic irtcv_rst_async
);

   initial begin
      irtcv_clk = 1'b0;
      forever #5 irtcv_clk = ~irtcv_clk;   // 10 ns period
   end

   // Reset held over the first three rising edges
   initial begin
      irtcv_rst_async = 1'b1;
      repeat (3) @(posedge irtcv_clk);
      @(negedge irtcv_clk);
      irtcv_rst_async = 1'b0;
   end

endmodule

//--- verif/irtcv_tb.sv
`timescale 1ns/10ps
`include "irtcv_defs.svh"

module irtcv_tb;

   import irtcv_pkg::*;

   localparam int st_busy   = 3;   // Status bit positions
   localparam int st_tip    = 2;
   localparam int st_daterr = 1;
   localparam int st_drdy   = 0;

   localparam int wait_start = 20;
   localparam int wait_calc  = 100;
   localparam int wait_word  = 400;   // Longest word is 4 periods of 60 clocks

   localparam ctrl_reg_t cr_en    = ctrl_reg_t'(1 << `IRTCV_CR_EN);
   localparam ctrl_reg_t cr_dt33  = ctrl_reg_t'(1 << `IRTCV_CR_DT33);
   localparam ctrl_reg_t cr_opol  = ctrl_reg_t'(1 << `IRTCV_CR_OPOL);
   localparam ctrl_reg_t cr_disoe = ctrl_reg_t'(1 << `IRTCV_CR_DISOE);

   logic          irtcv_clk;
   logic          irtcv_rst_async;
   logic          exe;
   ctrl_reg_t     irtcvcr;
   sysfr_t        irsysfr;
   carrier_freq_t irtcvfr;
   tx_word_t      irtcvdr;
   logic          irtcvcr_wt;
   logic          irtcvfr_wt;
   logic          irtcvdr_wt;
   logic          ir_out;
   status_t       status;

   logic [31:0]   lfsr;
   carrier_cnt_t  exp_period;   // Model results for the current carrier
   carrier_cnt_t  exp_duty;
   logic          chk_period;
   logic          act_now;
   logic          act_q;
   logic          have_rise;
   int            cyc;
   int            rise_cyc;
   int            rises;
   int            base_rises;   // Pulse count at the last word boundary

   irtcv_clk_gen irtcv_clk_gen_inst (
      .irtcv_clk       (irtcv_clk),
      .irtcv_rst_async (irtcv_rst_async)
   );

   irtcv_ctrl irtcv_ctrl_inst (
      .irtcv_clk       (irtcv_clk),
      .irtcv_rst_async (irtcv_rst_async),
      .exe             (exe),
      .irtcvcr         (irtcvcr),
      .irsysfr         (irsysfr),
      .irtcvfr         (irtcvfr),
      .irtcvdr         (irtcvdr),
      .irtcvcr_wt      (irtcvcr_wt),
      .irtcvfr_wt      (irtcvfr_wt),
      .irtcvdr_wt      (irtcvdr_wt),
      .ir_out          (ir_out),
      .status          (status)
   );

   // *********************************************************************
   // Error reporting and compares
   task automatic fail_now();
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic fail_with(input string what);
      $display("ERROR: %s", what);
      fail_now();
   endtask

   task automatic check_status(input string name, input status_t got, input status_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
         fail_now();
      end
   endtask

   task automatic check_cnt(input string name, input carrier_cnt_t got,
                            input carrier_cnt_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
         fail_now();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
         fail_now();
      end
   endtask

   // *********************************************************************
   // Random source and reference model
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};   // Taps 32 22 2 1
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Nearest integer, halves go up
   function automatic longint round_div(input longint num, input longint den);
      return (2 * num + den) / (2 * den);
   endfunction

   function automatic tx_word_t draw_word(input logic all_mark);
      logic [31:0] r;
      r = rand_bits(3);
      return {all_mark | r[2], burst_len_t'(r[1:0]) + burst_len_t'(1)};
   endfunction

   // Active pulses a word produces, one per carrier period of a mark
   function automatic carrier_cnt_t word_pulses(input tx_word_t w);
      burst_len_t len;
      len = w[`IRTCV_DR_W-2:0];
      if (len == '0) len = burst_len_t'(1);
      return w[`IRTCV_DR_W-1] ? carrier_cnt_t'(len) : '0;
   endfunction

   // *********************************************************************
   // Waveform monitor, edges of the active level while transmitting
   assign act_now = ir_out ^ irtcvcr[`IRTCV_CR_OPOL];

   always @(negedge irtcv_clk) begin
      cyc   <= cyc + 1;
      act_q <= act_now;
      if (irtcv_rst_async || !status[st_tip]) begin
         have_rise <= 1'b0;
      end else if (act_now && !act_q) begin
         rises     <= rises + 1;
         rise_cyc  <= cyc;
         have_rise <= 1'b1;
         if (chk_period && have_rise)
            check_cnt("carrier period", carrier_cnt_t'(cyc - rise_cyc), exp_period);
      end else if (!act_now && act_q && have_rise) begin
         check_cnt("active width", carrier_cnt_t'(cyc - rise_cyc), exp_duty);
      end
   end

   // *********************************************************************
   // Bus tasks, all driven on the falling edge
   task automatic wait_flag(input int idx, input logic val, input int limit,
                            input string what);
      int n;
      n = 0;
      while (status[idx] !== val) begin
         if (n == limit) fail_with({"timeout waiting for ", what});
         @(negedge irtcv_clk);
         n++;
      end
   endtask

   task automatic write_cr(input ctrl_reg_t cr);
      @(negedge irtcv_clk);
      irtcvcr    = cr;
      irtcvcr_wt = 1'b1;
      @(negedge irtcv_clk);
      irtcvcr_wt = 1'b0;
   endtask

   task automatic write_dr(input tx_word_t w);
      @(negedge irtcv_clk);
      irtcvdr    = w;
      irtcvdr_wt = 1'b1;
      @(negedge irtcv_clk);
      irtcvdr_wt = 1'b0;
   endtask

   // New control value and a random carrier, period 8 to 60 clocks
   task automatic configure(input ctrl_reg_t cr);
      longint f;
      longint p;
      longint s;
      f = 1024 + longint'(rand_bits(19));
      p = 8 + longint'(rand_bits(6)) % 53;
      s = f * p - f / 2 + longint'(rand_bits(20)) % f;
      exp_period = carrier_cnt_t'(round_div(s, f));
      exp_duty   = carrier_cnt_t'(round_div(longint'(exp_period),
                                            cr[`IRTCV_CR_DT33] ? 3 : 2));
      write_cr(cr);
      @(negedge irtcv_clk);
      irsysfr    = sysfr_t'(s);
      irtcvfr    = carrier_freq_t'(f);
      irtcvfr_wt = 1'b1;
      @(negedge irtcv_clk);
      irtcvfr_wt = 1'b0;
      wait_flag(st_busy, 1'b1, wait_start, "calculation start");
      wait_flag(st_busy, 1'b0, wait_calc, "calculation end");
      check_bit("ir_out", ir_out, cr[`IRTCV_CR_OPOL]);
   endtask

   task automatic start_tx(input tx_word_t w);
      write_dr(w);
      exe = 1'b1;
      wait_flag(st_tip, 1'b1, wait_start, "transmit start");
      wait_flag(st_drdy, 1'b1, wait_start, "first word capture");
      base_rises = rises;
   endtask

   task automatic word_boundary(input carrier_cnt_t exp);
      wait_flag(st_drdy, 1'b1, wait_word, "word capture");
      check_cnt("pulses per word", carrier_cnt_t'(rises - base_rises), exp);
      check_bit("daterr", status[st_daterr], 1'b0);
      base_rises = rises;
   endtask

   // Space word keeps drdy low at the final capture
   task automatic stop_tx(input carrier_cnt_t exp);
      write_dr(tx_word_t'(0));
      exe = 1'b0;
      wait_flag(st_tip, 1'b0, wait_word, "end of transmit");
      check_cnt("pulses per word", carrier_cnt_t'(rises - base_rises), exp);
      wait_flag(st_busy, 1'b0, wait_start, "busy to clear");
      check_status("status", status, 4'b0001);
      check_bit("ir_out", ir_out, irtcvcr[`IRTCV_CR_OPOL]);
   endtask

   task automatic run_words(input int n, input logic all_mark);
      tx_word_t     w;
      carrier_cnt_t prev;
      int           i;
      w = draw_word(all_mark);
      start_tx(w);
      prev = word_pulses(w);
      for (i = 1; i < n; i++) begin
         w = draw_word(all_mark);
         write_dr(w);
         word_boundary(prev);
         prev = word_pulses(w);
      end
      stop_tx(prev);
   endtask

   // *********************************************************************
   // Test sequence
   initial begin
      ctrl_reg_t cr;
      int        n;
      int        k;
      exe        = 1'b0;
      irtcvcr    = '0;
      irsysfr    = '0;
      irtcvfr    = '0;
      irtcvdr    = '0;
      irtcvcr_wt = 1'b0;
      irtcvfr_wt = 1'b0;
      irtcvdr_wt = 1'b0;
      lfsr       = 32'h3f44_6d31;
      chk_period = 1'b0;
      act_q      = 1'b0;
      have_rise  = 1'b0;
      cyc        = 0;
      rise_cyc   = 0;
      rises      = 0;
      base_rises = 0;
      n          = 0;
      while (irtcv_rst_async !== 1'b0) begin
         if (n == wait_start) fail_with("reset was never released");
         @(negedge irtcv_clk);
         n++;
      end
      @(negedge irtcv_clk);

      // After reset only drdy is up
      check_status("status", status, 4'b0001);
      check_bit("ir_out", ir_out, 1'b0);

      // Period and width, half and one-third duty
      chk_period = 1'b1;
      for (k = 0; k < 4; k++) begin
         configure((k % 2 == 1) ? (cr_en | cr_dt33) : cr_en);
         run_words(4, 1'b1);
      end
      chk_period = 1'b0;

      // Mixed mark and space words
      for (k = 0; k < 2; k++) begin
         cr = cr_en;
         if (rand_bits(1) == 32'd1) cr = cr | cr_dt33;
         configure(cr);
         run_words(8, 1'b0);
      end

      // Underrun with output muted on error
      configure(cr_en | cr_disoe);
      start_tx(16'h8001);
      wait_flag(st_daterr, 1'b1, wait_word, "data error");
      check_status("status", status, 4'b1011);
      check_bit("ir_out", ir_out, 1'b0);
      write_dr(16'h8002);
      wait_flag(st_tip, 1'b1, wait_start, "transmit restart");
      wait_flag(st_drdy, 1'b1, wait_start, "word capture");
      base_rises = rises;
      write_dr(16'h0001);
      wait_flag(st_drdy, 1'b1, wait_word, "word capture");
      check_cnt("muted pulses", carrier_cnt_t'(rises - base_rises), '0);
      check_bit("ir_out", ir_out, 1'b0);
      base_rises = rises;
      write_cr(cr_en | cr_disoe);
      check_bit("daterr", status[st_daterr], 1'b0);
      write_dr(16'h8002);
      word_boundary('0);
      stop_tx(16'd2);

      // Inverted output
      chk_period = 1'b1;
      configure(cr_en | cr_opol | cr_dt33);
      run_words(4, 1'b1);
      chk_period = 1'b0;
      run_words(6, 1'b0);

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- sources.f
+incdir+hw
hw/irtcv_pkg.sv
hw/irtcv_divider.sv
hw/irtcv_carrier_calc.sv
hw/irtcv_tx_seq.sv
hw/irtcv_burst_gen.sv
hw/irtcv_ctrl.sv
verif/irtcv_clk_gen.sv
verif/irtcv_tb.sv

//--- Makefile
# Verilator build and run of the IR transmit controller testbench

VERILATOR ?= verilator
TOP       ?= irtcv_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
